/* Makefile */
# Verilator build and run for the load/store data path

.PHONY: all compile run clean

all: run

compile: obj_dir/Vlsu_tb

obj_dir/Vlsu_tb: all.f hdl/*.sv tests/*.sv
	verilator --binary --timing --assert -f all.f --top-module lsu_tb -o Vlsu_tb

# the simulator output goes to run.log; the pass line decides the result
run: compile
	./obj_dir/Vlsu_tb > run.log 2>&1 ; cat run.log
	grep -q "^Test OK$$" run.log

clean:
	rm -rf obj_dir run.log

/* all.f */
hdl/lsu_pkg.sv
hdl/mem_req_decode.sv
hdl/data_mem.sv
hdl/load_extend.sv
hdl/lsu_top.sv
tests/lsu_asserts.sv
tests/lsu_tb.sv

/* hdl/data_mem.sv */
`default_nettype none
`timescale 1ns/100ps

module data_mem
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  mem_op_t  op_i,   // decoded request
    output mem_rsp_t rsp_o   // registered result, one cycle later
);

    // byte array, contents start unknown
    logic [7:0] mem [0:MEM_BYTES-1];

    logic        wr_en;
    logic [31:0] rd_lanes;  // bytes at addr..addr+3, disabled lanes zero

    assign wr_en = op_i.valid & op_i.store & ~op_i.err;

    // store: enabled lanes go to addr and its successors
    // in-range check guarantees no lane runs past MEM_TOP
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (op_i.be[i]) begin
                    mem[op_i.addr + ADDR_W'(i)] <= op_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // gather the load lanes, little-endian
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (op_i.be[i]) begin
                rd_lanes[8*i +: 8] = mem[op_i.addr + ADDR_W'(i)];
            end else begin
                rd_lanes[8*i +: 8] = 8'h00;
            end
        end
    end

    // response valid is the only control bit under reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rsp_o.valid <= 1'b0;
        end else begin
            rsp_o.valid <= op_i.valid;
        end
    end

    // payload, captured for every request
    always_ff @(posedge clk) begin
        if (op_i.valid) begin
            rsp_o.store <= op_i.store;
            rsp_o.err   <= op_i.err;
            rsp_o.width <= op_i.width;
            rsp_o.uns   <= op_i.uns;
            if (op_i.err) begin
                rsp_o.data <= ERR_DATA;      // marker for a failed load
            end else if (op_i.store) begin
                rsp_o.data <= 32'h0000_0000; // nothing to return
            end else begin
                rsp_o.data <= rd_lanes;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/load_extend.sv */
`default_nettype none
`timescale 1ns/100ps

module load_extend
    import lsu_pkg::*;
(
    input  mem_rsp_t    rsp_i,       // registered memory result
    output logic        rd_valid_o,  // load result valid
    output logic [31:0] rd_data_o,   // extended load data
    output logic        err_o,       // request was out of range
    output logic        st_done_o    // store completed
);

    logic byte_sign;
    logic half_sign;

    // sign bits, forced low for unsigned loads
    assign byte_sign = rsp_i.data[7]  & ~rsp_i.uns;
    assign half_sign = rsp_i.data[15] & ~rsp_i.uns;

    always_comb begin
        if (rsp_i.err) begin
            rd_data_o = rsp_i.data;  // error marker goes out untouched
        end else begin
            case (rsp_i.width)
                MEM_BYTE: rd_data_o = {{24{byte_sign}}, rsp_i.data[7:0]};
                MEM_HALF: rd_data_o = {{16{half_sign}}, rsp_i.data[15:0]};
                default:  rd_data_o = rsp_i.data;  // word, no extension
            endcase
        end
    end

    // one valid bit split into load and store strobes
    assign rd_valid_o = rsp_i.valid & ~rsp_i.store;
    assign st_done_o  = rsp_i.valid &  rsp_i.store;
    assign err_o      = rsp_i.valid &  rsp_i.err;

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data memory geometry
    localparam int          MEM_BYTES = 131072;        // 128 KiB
    localparam logic [31:0] MEM_TOP   = 32'h0001FFFF;  // last legal byte address
    localparam int          ADDR_W    = 17;            // local byte address width

    // marker returned by a load that fails the range check
    localparam logic [31:0] ERR_DATA  = 32'hDEADBEEF;

    // access width as coded by the execute stage
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_width_e;

    // request from execute, one per cycle, no back-pressure
    typedef struct packed {
        logic        valid;
        logic        store;   // 1 = store, 0 = load
        mem_width_e  width;
        logic        uns;     // zero extend on load
        logic [31:0] addr;    // full byte address
        logic [31:0] wdata;
    } mem_req_t;

    // decoded request into the memory
    typedef struct packed {
        logic              valid;
        logic              store;
        logic [3:0]        be;      // byte lanes, lane 0 at addr
        logic              err;     // out of range or bad width
        mem_width_e        width;
        logic              uns;
        logic [ADDR_W-1:0] addr;    // local byte address
        logic [31:0]       wdata;
    } mem_op_t;

    // registered memory result
    typedef struct packed {
        logic        valid;
        logic        store;
        logic        err;
        mem_width_e  width;
        logic        uns;
        logic [31:0] data;    // raw lanes, or error marker
    } mem_rsp_t;

endpackage

`default_nettype wire

/* hdl/lsu_top.sv */
`default_nettype none
`timescale 1ns/100ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  mem_req_t    req_i,       // from execute stage
    output logic        rd_valid_o,
    output logic [31:0] rd_data_o,
    output logic        err_o,
    output logic        st_done_o
);

    mem_op_t  op;   // decode -> memory, same cycle
    mem_rsp_t rsp;  // memory -> extend, one cycle later

    mem_req_decode u_decode (
        .req_i (req_i),
        .op_o  (op)
    );

    data_mem u_mem (
        .clk     (clk),
        .reset_i (reset_i),
        .op_i    (op),
        .rsp_o   (rsp)
    );

    load_extend u_extend (
        .rsp_i      (rsp),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .err_o      (err_o),
        .st_done_o  (st_done_o)
    );

endmodule

`default_nettype wire

/* hdl/mem_req_decode.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_req_decode
    import lsu_pkg::*;
(
    input  mem_req_t req_i,  // request from execute
    output mem_op_t  op_o    // decoded op to data memory
);

    logic [3:0]  byte_en;
    logic [32:0] last_off;   // byte count minus one
    logic [32:0] last_addr;  // address of the last byte touched
    logic        width_bad;
    logic        range_bad;

    // width code to byte lanes
    always_comb begin
        byte_en   = 4'b0000;
        last_off  = '0;
        width_bad = 1'b0;
        case (req_i.width)
            MEM_BYTE: begin
                byte_en  = 4'b0001;
                last_off = 33'd0;
            end
            MEM_HALF: begin
                byte_en  = 4'b0011;
                last_off = 33'd1;
            end
            MEM_WORD: begin
                byte_en  = 4'b1111;
                last_off = 33'd3;
            end
            default: begin
                width_bad = 1'b1;  // unused code, treat as error
            end
        endcase
    end

    // range check on the full address
    // one extra bit so 0xFFFFFFFF plus offset cannot wrap back in range
    assign last_addr = {1'b0, req_i.addr} + last_off;
    assign range_bad = (last_addr > {1'b0, MEM_TOP});

    always_comb begin
        op_o.valid = req_i.valid;
        op_o.store = req_i.store;
        op_o.be    = byte_en;
        op_o.err   = range_bad | width_bad;
        op_o.width = req_i.width;
        op_o.uns   = req_i.uns;
        op_o.addr  = req_i.addr[ADDR_W-1:0];  // low bits index the byte array
        op_o.wdata = req_i.wdata;
    end

endmodule

`default_nettype wire

/* tests/lsu_asserts.sv */
`default_nettype none
`timescale 1ns/100ps

module lsu_asserts
    import lsu_pkg::*;
(
    input logic     clk,
    input logic     reset_i,
    input mem_req_t req_i,
    input logic     rd_valid_i,
    input logic     err_i,
    input logic     st_done_i
);

    logic any_strobe;

    assign any_strobe = rd_valid_i | st_done_i;

    // a response is either a load or a store, never both
    a_one_strobe: assert property (@(posedge clk) !(rd_valid_i && st_done_i))
        else $error("load and store strobes high in the same cycle");

    a_err_with_strobe: assert property (@(posedge clk) err_i |-> any_strobe)
        else $error("err_o high without a load or store strobe");

    // synchronous reset clears the response valid bit at the edge
    a_reset_quiet: assert property (@(posedge clk) reset_i |=> !(any_strobe || err_i))
        else $error("strobe high right after reset");

    // fixed one cycle latency, no back-pressure
    a_strobe_follows: assert property (@(posedge clk) disable iff (reset_i)
        req_i.valid |=> any_strobe)
        else $error("no strobe one cycle after a valid request");

    a_no_spurious: assert property (@(posedge clk) disable iff (reset_i)
        !req_i.valid |=> !any_strobe)
        else $error("strobe without a request one cycle earlier");

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clk        (clk),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .rd_valid_i (rd_valid_o),
    .err_i      (err_o),
    .st_done_i  (st_done_o)
);

`default_nettype wire

/* tests/lsu_stim.txt */
# gap store width(0 byte,1 half,2 word) unsigned addr wdata exp_data exp_err
# gap = idle cycles before the request; exp_data is checked for loads only
0 1 2 0 00000100 12345678 00000000 0
0 0 2 0 00000100 00000000 12345678 0
3 0 2 0 00000100 00000000 12345678 0
2 1 2 0 00000200 cafef00d 00000000 0
0 0 2 0 00000200 00000000 cafef00d 0
0 1 0 0 00000300 000000aa 00000000 0
0 1 0 0 00000301 00000011 00000000 0
0 1 1 0 00000302 0000b2c3 00000000 0
0 0 2 0 00000300 00000000 b2c311aa 0
0 1 1 0 00000304 ffff8001 00000000 0
0 1 0 0 00000306 1234567f 00000000 0
0 1 0 0 00000307 abcdef90 00000000 0
0 0 2 0 00000304 00000000 907f8001 0
0 0 0 0 00000300 00000000 ffffffaa 0
0 0 0 1 00000300 00000000 000000aa 0
0 0 0 0 00000301 00000000 00000011 0
0 0 1 0 00000302 00000000 ffffb2c3 0
0 0 1 1 00000302 00000000 0000b2c3 0
1 0 1 0 00000304 00000000 ffff8001 0
0 0 1 1 00000304 00000000 00008001 0
0 0 1 0 00000306 00000000 ffff907f 0
0 0 0 0 00000306 00000000 0000007f 0
0 0 2 1 00000300 00000000 b2c311aa 0
0 1 2 0 00000403 89abcdef 00000000 0
0 0 2 0 00000403 00000000 89abcdef 0
0 0 0 1 00000404 00000000 000000cd 0
0 0 1 0 00000405 00000000 ffff89ab 0
0 1 1 0 00000401 00005566 00000000 0
0 0 2 0 00000401 00000000 cdef5566 0
0 0 1 1 00000403 00000000 0000cdef 0
2 1 2 0 00000000 0badf00d 00000000 0
0 1 2 0 0001fffc 11223344 00000000 0
0 0 2 0 0001fffc 00000000 11223344 0
0 1 0 0 0001ffff 000000a5 00000000 0
0 0 0 0 0001ffff 00000000 ffffffa5 0
0 1 1 0 0001fffe 00007e6d 00000000 0
0 0 1 0 0001fffe 00000000 00007e6d 0
0 0 2 0 0001fffc 00000000 7e6d3344 0
0 0 2 0 0001fffd 00000000 deadbeef 1
0 0 1 0 0001ffff 00000000 deadbeef 1
0 0 0 0 00020000 00000000 deadbeef 1
0 0 0 1 00020000 00000000 deadbeef 1
0 0 0 0 ffffffff 00000000 deadbeef 1
1 1 2 0 0001fffd ffffffff 00000000 1
0 1 1 0 0001ffff 0000ffff 00000000 1
0 1 0 0 00020000 000000ff 00000000 1
0 1 0 0 00020100 000000ff 00000000 1
0 0 2 0 0001fffc 00000000 7e6d3344 0
0 0 0 1 0001ffff 00000000 0000007e 0
0 0 2 0 00000000 00000000 0badf00d 0
0 0 2 0 00000100 00000000 12345678 0

/* tests/lsu_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module lsu_tb
    import lsu_pkg::*;
();

    logic        clk;
    logic        reset_i;
    mem_req_t    req;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        err;
    logic        st_done;
    int          line_count;

    lsu_top u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .req_i      (req),
        .rd_valid_o (rd_valid),
        .rd_data_o  (rd_data),
        .err_o      (err),
        .st_done_o  (st_done)
    );

    always #5 clk = ~clk;  // 10 ns period

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input logic [31:0] exp);
        if (rd_data !== exp) begin
            fail_now($sformatf("error at %0t: rd_data_o = %h, expected %h (line %0d)",
                               $time, rd_data, exp, line_count));
        end
    endtask

    task automatic check_err(input logic exp);
        if (err !== exp) begin
            fail_now($sformatf("error at %0t: err_o = %b, expected %b (line %0d)",
                               $time, err, exp, line_count));
        end
    endtask

    // load and store strobes compared as one pair
    task automatic check_strobe(input logic exp_rd, input logic exp_st);
        if (rd_valid !== exp_rd || st_done !== exp_st) begin
            fail_now($sformatf(
                "error at %0t: rd_valid_o/st_done_o = %b%b, expected %b%b (line %0d)",
                $time, rd_valid, st_done, exp_rd, exp_st, line_count));
        end
    endtask

    task automatic drive_request(input logic st, input mem_width_e w, input logic u,
                                 input logic [31:0] a, input logic [31:0] d);
        req.valid = 1'b1;
        req.store = st;
        req.width = w;
        req.uns   = u;
        req.addr  = a;
        req.wdata = d;
    endtask

    // returns 1 ns after the edge that brought a strobe
    task automatic wait_result();
        int cycles;
        @(posedge clk);
        #1;
        req.valid = 1'b0;  // one cycle pulse
        cycles = 1;
        while (!(rd_valid || st_done) && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!(rd_valid || st_done)) begin
            fail_now($sformatf("no load or store result appeared within %0d cycles (line %0d)",
                               cycles, line_count));
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       text;
        int          gap;
        int          st;
        int          wcode;
        int          uns;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        int          exp_err;

        clk         = 1'b0;
        reset_i     = 1'b1;
        req         = '0;
        line_count  = 0;

        fd = $fopen("tests/lsu_stim.txt", "r");
        if (fd == 0) begin
            fail_now("could not open the stimulus file tests/lsu_stim.txt");
        end

        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_strobe(1'b0, 1'b0);  // quiet after reset
        check_err(1'b0);

        while (!$feof(fd)) begin
            n = $fgets(text, fd);
            if (n == 0 || text.len() < 2 || text.getc(0) == "#") begin
                continue;  // blank or comment
            end
            n = $sscanf(text, "%d %d %d %d %h %h %h %d",
                        gap, st, wcode, uns, addr, wdata, exp_data, exp_err);
            line_count++;
            if (n != 8) begin
                fail_now($sformatf("stimulus line %0d has %0d fields instead of 8",
                                   line_count, n));
            end

            repeat (gap) begin
                @(posedge clk);
                #1;
            end

            drive_request(st[0], mem_width_e'(wcode[1:0]), uns[0], addr, wdata);
            wait_result();
            check_strobe(st == 0, st == 1);
            check_err(exp_err[0]);
            if (st == 0) begin
                check_data(exp_data);
            end
        end
        $fclose(fd);

        if (line_count == 0) begin
            fail_now("the stimulus file held no requests");
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
